// File: design/softex_pkg.sv
package softex_pkg;

    // stream and lane widths.
    localparam int unsigned DATA_W    = 32;             // stream data width.
    localparam int unsigned INT_W     = 8;              // integer lane width.
    localparam int unsigned FP_W      = 16;             // bfloat16 slot width.

    // bfloat16 encoding.
    localparam int unsigned EXP_BITS  = 8;              // exponent field.
    localparam int unsigned MAN_BITS  = 7;              // stored mantissa, hidden one dropped.
    localparam int unsigned FP_BIAS   = 127;            // exponent bias.

    localparam int unsigned NUM_LANES = DATA_W / FP_W;  // lanes per stream word.

    // APB word addresses of the cast register block.
    typedef enum logic [7:0] {
        REG_CTRL = 8'h00,
        REG_INFO = 8'h04
    } cast_reg_e;

    // REG_CTRL field positions.
    localparam int unsigned CTRL_ENABLE_BIT   = 0;      // cast on, bypass off.
    localparam int unsigned CTRL_SIGNED_BIT   = 1;      // lanes are two's complement.
    localparam int unsigned CTRL_INT_BITS_LSB = 4;
    localparam int unsigned CTRL_INT_BITS_MSB = 7;

    // REG_INFO field positions.
    localparam int unsigned INFO_LANES_LSB    = 0;
    localparam int unsigned INFO_LANES_MSB    = 3;
    localparam int unsigned INFO_WIDTH_LSB    = 8;
    localparam int unsigned INFO_WIDTH_MSB    = 15;

endpackage

// File: design/softex_lzc_tree.sv
`timescale 1ns/1ps

module softex_lzc_tree #(
    parameter int unsigned INT_WIDTH = softex_pkg::INT_W
) (
    input  logic [INT_WIDTH-1:0]          lane_i,
    output logic [$clog2(INT_WIDTH):0]    lz_o,
    output logic                          zero_o
);

    localparam int unsigned NUM_PAIRS  = INT_WIDTH / 2;
    localparam int unsigned TREE_DEPTH = $clog2(NUM_PAIRS);
    localparam int unsigned CNT_W      = $clog2(INT_WIDTH) + 1;

    // one row of counts per tree level, level 0 holds the pair encodings.
    logic [TREE_DEPTH:0][NUM_PAIRS-1:0][CNT_W-1:0] cnt;

    always_comb begin
        cnt = '0;

        // leaf encoders, one per bit pair.
        for (int p = 0; p < NUM_PAIRS; p++) begin
            case (lane_i[2*p +: 2])
                2'b00:   cnt[0][p] = CNT_W'(2);
                2'b01:   cnt[0][p] = CNT_W'(1);
                default: cnt[0][p] = '0;    // leading one in the upper bit.
            endcase
        end

        // each level halves the node count and doubles the group size.
        for (int k = 0; k < TREE_DEPTH; k++) begin
            for (int n = 0; n < (NUM_PAIRS >> (k + 1)); n++) begin
                if (cnt[k][2*n+1][k+1]) begin
                    // upper group all zero, keep counting into the lower one.
                    cnt[k+1][n] = CNT_W'(2 << k) + cnt[k][2*n];
                end else begin
                    cnt[k+1][n] = cnt[k][2*n+1];
                end
            end
        end
    end

    assign lz_o   = cnt[TREE_DEPTH][0];
    assign zero_o = lz_o[CNT_W-1];          // count equals the lane width.

endmodule

// File: design/softex_cast_in.sv
`timescale 1ns/1ps

module softex_cast_in #(
    parameter int unsigned DATA_WIDTH = softex_pkg::DATA_W,
    parameter int unsigned INT_WIDTH  = softex_pkg::INT_W
) (
    input  logic                      enable_i,
    input  logic                      is_signed_i,
    input  logic [3:0]                int_bits_i,
    input  logic [DATA_WIDTH-1:0]     data_i,
    input  logic [DATA_WIDTH/8-1:0]   strb_i,
    output logic [DATA_WIDTH-1:0]     data_o,
    output logic [DATA_WIDTH/8-1:0]   strb_o
);

    import softex_pkg::*;

    localparam int unsigned LANES     = DATA_WIDTH / FP_W;
    localparam int unsigned SLOT_STRB = FP_W / 8;
    localparam int unsigned LZ_W      = $clog2(INT_WIDTH) + 1;

    logic [LANES-1:0][FP_W-1:0]      cast_data;
    logic [LANES-1:0][SLOT_STRB-1:0] cast_strb;

    for (genvar i = 0; i < LANES; i++) begin : gen_lanes
        logic [INT_WIDTH-1:0] raw;
        logic                 sign;
        logic [INT_WIDTH-1:0] mag;
        logic [LZ_W-1:0]      lz;
        logic                 zero;
        logic [INT_WIDTH-1:0] norm;
        logic [EXP_BITS-1:0]  expo;
        logic [MAN_BITS-1:0]  man;

        assign raw  = data_i[i*FP_W +: INT_WIDTH];     // integer in the low half of the slot.
        assign sign = is_signed_i & raw[INT_WIDTH-1];
        assign mag  = sign ? (~raw + 1'b1) : raw;      // -128 maps to 128 unsigned.

        softex_lzc_tree #(
            .INT_WIDTH ( INT_WIDTH )
        ) i_lzc (
            .lane_i    ( mag       ),
            .lz_o      ( lz        ),
            .zero_o    ( zero      )
        );

        // shift out the leading one, the remaining bits form the fraction.
        assign norm = mag << (lz + 1'b1);
        assign man  = norm[INT_WIDTH-1 -: MAN_BITS];

        // bias - 1 - lz + is_signed + int_bits, modulo the field width.
        assign expo = zero ? '0 :
                      EXP_BITS'(FP_BIAS - 1) - EXP_BITS'(lz)
                      + EXP_BITS'(is_signed_i) + EXP_BITS'(int_bits_i);

        assign cast_data[i] = {sign, expo, man};       // zero keeps its sign.
        assign cast_strb[i] = {SLOT_STRB{strb_i[i*SLOT_STRB]}};
    end

    // disabled stage is a plain wire path.
    assign data_o = enable_i ? cast_data : data_i;
    assign strb_o = enable_i ? cast_strb : strb_i;

endmodule

// File: design/softex_cast_regs.sv
`timescale 1ns/1ps

module softex_cast_regs (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [7:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    output logic        enable_o,
    output logic        is_signed_o,
    output logic [3:0]  int_bits_o
);

    import softex_pkg::*;

    logic       access;
    logic       enable_q;
    logic       is_signed_q;
    logic [3:0] int_bits_q;

    assign access   = psel_i & penable_i;   // access phase of a transfer.
    assign pready_o = 1'b1;                 // no wait states.

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enable_q    <= 1'b0;            // bypass out of reset.
            is_signed_q <= 1'b0;
            int_bits_q  <= '0;
        end else if (access && pwrite_i && paddr_i == REG_CTRL) begin
            enable_q    <= pwdata_i[CTRL_ENABLE_BIT];
            is_signed_q <= pwdata_i[CTRL_SIGNED_BIT];
            int_bits_q  <= pwdata_i[CTRL_INT_BITS_MSB:CTRL_INT_BITS_LSB];
        end
    end

    // read mux and error decode.
    always_comb begin
        prdata_o  = '0;
        pslverr_o = 1'b0;
        case (paddr_i)
            REG_CTRL: begin
                prdata_o[CTRL_ENABLE_BIT]                       = enable_q;
                prdata_o[CTRL_SIGNED_BIT]                       = is_signed_q;
                prdata_o[CTRL_INT_BITS_MSB:CTRL_INT_BITS_LSB]   = int_bits_q;
            end
            REG_INFO: begin
                prdata_o[INFO_LANES_MSB:INFO_LANES_LSB] = 4'(NUM_LANES);
                prdata_o[INFO_WIDTH_MSB:INFO_WIDTH_LSB] = 8'(INT_W);
                pslverr_o = access & pwrite_i;  // read only.
            end
            default: begin
                pslverr_o = access;             // unmapped.
            end
        endcase
    end

    assign enable_o    = enable_q;
    assign is_signed_o = is_signed_q;
    assign int_bits_o  = int_bits_q;

endmodule

// File: design/softex_stream_buffer.sv
`timescale 1ns/1ps

module softex_stream_buffer #(
    parameter int unsigned DATA_WIDTH = softex_pkg::DATA_W
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    output logic                      ready_o,
    input  logic [DATA_WIDTH-1:0]     data_i,
    input  logic [DATA_WIDTH/8-1:0]   strb_i,
    output logic                      valid_o,
    input  logic                      ready_i,
    output logic [DATA_WIDTH-1:0]     data_o,
    output logic [DATA_WIDTH/8-1:0]   strb_o
);

    localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

    logic [1:0][DATA_WIDTH-1:0] data_q;
    logic [1:0][STRB_WIDTH-1:0] strb_q;
    logic                       wr_ptr_q;
    logic                       rd_ptr_q;
    logic [1:0]                 count_q;    // 0 to 2 words held.
    logic                       push;
    logic                       pop;

    assign valid_o = (count_q != 2'd0);
    assign pop     = valid_o & ready_i;
    assign ready_o = (count_q != 2'd2) | pop;   // full but draining still accepts.
    assign push    = valid_i & ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;    // idle or pass-through.
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            data_q[wr_ptr_q] <= data_i;
            strb_q[wr_ptr_q] <= strb_i;
        end
    end

    assign data_o = data_q[rd_ptr_q];
    assign strb_o = strb_q[rd_ptr_q];

endmodule

// File: design/softex_cast_top.sv
`timescale 1ns/1ps

module softex_cast_top #(
    parameter int unsigned DATA_WIDTH = softex_pkg::DATA_W,
    parameter int unsigned INT_WIDTH  = softex_pkg::INT_W
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // APB
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [7:0]                paddr_i,
    input  logic [31:0]               pwdata_i,
    output logic [31:0]               prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    // input stream
    input  logic                      in_valid_i,
    output logic                      in_ready_o,
    input  logic [DATA_WIDTH-1:0]     in_data_i,
    input  logic [DATA_WIDTH/8-1:0]   in_strb_i,
    // output stream
    output logic                      out_valid_o,
    input  logic                      out_ready_i,
    output logic [DATA_WIDTH-1:0]     out_data_o,
    output logic [DATA_WIDTH/8-1:0]   out_strb_o
);

    logic                    enable;
    logic                    is_signed;
    logic [3:0]              int_bits;
    logic [DATA_WIDTH-1:0]   cast_data;
    logic [DATA_WIDTH/8-1:0] cast_strb;

    softex_cast_regs i_regs (
        .clk_i       ( clk_i      ),
        .rst_n_i     ( rst_n_i    ),
        .psel_i      ( psel_i     ),
        .penable_i   ( penable_i  ),
        .pwrite_i    ( pwrite_i   ),
        .paddr_i     ( paddr_i    ),
        .pwdata_i    ( pwdata_i   ),
        .prdata_o    ( prdata_o   ),
        .pready_o    ( pready_o   ),
        .pslverr_o   ( pslverr_o  ),
        .enable_o    ( enable     ),
        .is_signed_o ( is_signed  ),
        .int_bits_o  ( int_bits   )
    );

    // combinational cast ahead of the buffer write port.
    softex_cast_in #(
        .DATA_WIDTH  ( DATA_WIDTH ),
        .INT_WIDTH   ( INT_WIDTH  )
    ) i_cast (
        .enable_i    ( enable     ),
        .is_signed_i ( is_signed  ),
        .int_bits_i  ( int_bits   ),
        .data_i      ( in_data_i  ),
        .strb_i      ( in_strb_i  ),
        .data_o      ( cast_data  ),
        .strb_o      ( cast_strb  )
    );

    softex_stream_buffer #(
        .DATA_WIDTH  ( DATA_WIDTH  )
    ) i_buffer (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .valid_i     ( in_valid_i  ),
        .ready_o     ( in_ready_o  ),
        .data_i      ( cast_data   ),
        .strb_i      ( cast_strb   ),
        .valid_o     ( out_valid_o ),
        .ready_i     ( out_ready_i ),
        .data_o      ( out_data_o  ),
        .strb_o      ( out_strb_o  )
    );

endmodule

// File: tests/tb_softex_cast.sv
`timescale 1ns/1ps

module tb_softex_cast;

    import softex_pkg::*;

    localparam int N_RAND       = 12;                   // random words per stream run.
    localparam int N_WORDS      = 5 * N_RAND + 20;      // stream words over the whole run.
    localparam int N_APB        = 20;
    localparam int LIMIT_CYCLES = N_WORDS * 8 + N_APB * 4 + 200;

    logic              clk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [7:0]        paddr;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    logic              in_valid;
    logic              in_ready;
    logic [DATA_W-1:0] in_data;
    logic [3:0]        in_strb;
    logic              out_valid;
    logic              out_ready;
    logic [DATA_W-1:0] out_data;
    logic [3:0]        out_strb;

    logic [31:0]       lfsr = 32'h2173_b3a7;
    logic [DATA_W-1:0] stim_data[$];
    logic [3:0]        stim_strb[$];
    logic              cfg_en;
    logic              cfg_sgn;
    logic [3:0]        cfg_ib;
    string             test_name;                       // test now running.
    int                err_cnt;
    int                tests_passed;
    int                tests_failed;

    softex_cast_top #(
        .DATA_WIDTH  ( DATA_W    ),
        .INT_WIDTH   ( INT_W     )
    ) uut (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .psel_i      ( psel      ),
        .penable_i   ( penable   ),
        .pwrite_i    ( pwrite    ),
        .paddr_i     ( paddr     ),
        .pwdata_i    ( pwdata    ),
        .prdata_o    ( prdata    ),
        .pready_o    ( pready    ),
        .pslverr_o   ( pslverr   ),
        .in_valid_i  ( in_valid  ),
        .in_ready_o  ( in_ready  ),
        .in_data_i   ( in_data   ),
        .in_strb_i   ( in_strb   ),
        .out_valid_o ( out_valid ),
        .out_ready_i ( out_ready ),
        .out_data_o  ( out_data  ),
        .out_strb_o  ( out_strb  )
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;                               // 8 ns period.

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];    // taps 32, 22, 2, 1.
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // expected {strobe, word} for one input word.
    function automatic logic [35:0] cast_model(input logic en, input logic sgn,
                                               input logic [3:0] ib, input logic [31:0] d,
                                               input logic [3:0] s);
        logic [31:0] w;
        logic [3:0]  ws;
        logic [7:0]  x;
        logic [7:0]  m;
        logic [7:0]  sh;
        logic [7:0]  e;
        logic        sign;
        int          p;
        if (!en) begin
            return {s, d};
        end
        w  = '0;
        ws = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            x    = d[i*FP_W +: INT_W];
            sign = sgn && x[7];
            m    = sign ? (8'd0 - x) : x;
            if (m == 8'd0) begin
                w[i*FP_W +: FP_W] = {sign, 15'd0};
            end else begin
                p = 7;
                while (!m[p]) begin
                    p--;
                end
                sh = m << (7 - p);                      // leading one to bit 7.
                e  = 8'(FP_BIAS + p + ib + sgn - INT_W);    // m * 2^(ib + sgn - 8).
                w[i*FP_W +: FP_W] = {sign, e, sh[6:0]};
            end
            ws[2*i +: 2] = {2{s[2*i]}};
        end
        return {ws, w};
    endfunction

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            err_cnt++;
            $display("Mismatch %s %s: expected %h, actual %h", test_name, name, exp, act);
        end
    endtask

    task automatic check_strb(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            err_cnt++;
            $display("Mismatch %s %s: expected %b, actual %b", test_name, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_cnt++;
            $display("Mismatch %s %s: expected %b, actual %b", test_name, name, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            tests_passed++;
            $display("pass  %s", name);
        end else begin
            tests_failed++;
            $display("fail  %s with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;                                 // setup phase.
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        rdata = prdata;                                 // edge that ends the access phase.
        err   = pslverr;
        check_bit("apb pready", 1'b1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata, output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, wdata, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata, output logic err);
        apb_access(1'b0, addr, 32'd0, rdata, err);
    endtask

    task automatic set_ctrl(input logic en, input logic sgn, input logic [3:0] ib);
        logic err;
        apb_write(REG_CTRL, {24'd0, ib, 2'b00, sgn, en}, err);
        check_bit("ctrl write error", 1'b0, err);
        cfg_en  = en;
        cfg_sgn = sgn;
        cfg_ib  = ib;
    endtask

    task automatic push(input logic [31:0] d, input logic [3:0] s);
        @(negedge clk);
        in_valid = 1'b1;
        in_data  = d;
        in_strb  = s;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic pop(output logic [31:0] d, output logic [3:0] s);
        @(negedge clk);
        out_ready = 1'b1;
        @(posedge clk);
        while (!out_valid) begin
            @(posedge clk);
        end
        d = out_data;
        s = out_strb;
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    task automatic add_random(input int n);
        for (int k = 0; k < n; k++) begin
            stim_data.push_back(rand_bits(32));
            stim_strb.push_back(rand_bits(4));
        end
    endtask

    // lane values in the low bytes, noise in the ignored high bytes.
    task automatic add_lanes(input logic [7:0] l1, input logic [7:0] l0);
        logic [31:0] r;
        r = rand_bits(16);
        stim_data.push_back({r[15:8], l1, r[7:0], l0});
        stim_strb.push_back(4'hf);
    endtask

    task automatic run_stream(input string name);
        logic [35:0] exp;
        logic [31:0] d;
        logic [3:0]  s;
        fork
            for (int k = 0; k < stim_data.size(); k++) begin
                push(stim_data[k], stim_strb[k]);
            end
            for (int k = 0; k < stim_data.size(); k++) begin
                pop(d, s);
                exp = cast_model(cfg_en, cfg_sgn, cfg_ib, stim_data[k], stim_strb[k]);
                check_word(name, exp[31:0], d);
                check_strb(name, exp[35:32], s);
            end
        join
        stim_data.delete();
        stim_strb.delete();
    endtask

    task automatic test_registers();
        int          e0;
        logic [31:0] rd;
        logic        err;
        test_name = "registers";
        e0 = err_cnt;
        @(posedge clk);
        check_bit("reset out_valid", 1'b0, out_valid);
        check_bit("reset in_ready", 1'b1, in_ready);
        check_bit("reset pslverr", 1'b0, pslverr);
        apb_read(REG_CTRL, rd, err);
        check_word("ctrl after reset", 32'd0, rd);
        check_bit("ctrl read error", 1'b0, err);
        apb_read(REG_INFO, rd, err);
        check_word("info", {16'd0, 8'(INT_W), 4'd0, 4'(NUM_LANES)}, rd);
        check_bit("info read error", 1'b0, err);
        apb_write(REG_CTRL, 32'hffff_ff5d, err);        // only bits 7:4, 1 and 0 stick.
        apb_read(REG_CTRL, rd, err);
        check_word("ctrl readback", 32'h0000_0051, rd);
        apb_write(8'h08, 32'd0, err);
        check_bit("unmapped write error", 1'b1, err);
        apb_read(8'h0c, rd, err);
        check_bit("unmapped read error", 1'b1, err);
        apb_write(REG_INFO, 32'hffff_ffff, err);
        check_bit("info write error", 1'b1, err);
        apb_read(REG_CTRL, rd, err);
        check_word("ctrl kept", 32'h0000_0051, rd);
        set_ctrl(1'b0, 1'b0, 4'd0);
        finish_test("registers", e0);
    endtask

    task automatic test_bypass();
        int e0;
        test_name = "bypass";
        e0 = err_cnt;
        set_ctrl(1'b0, 1'b0, 4'd0);
        add_random(N_RAND);
        run_stream("bypass");
        finish_test("bypass", e0);
    endtask

    task automatic test_unsigned();
        int e0;
        test_name = "unsigned cast";
        e0 = err_cnt;
        set_ctrl(1'b1, 1'b0, 4'd0);
        add_lanes(8'd0, 8'd1);
        add_lanes(8'd255, 8'd0);
        add_lanes(8'd1, 8'd255);
        add_random(N_RAND);
        run_stream("unsigned int_bits 0");
        set_ctrl(1'b1, 1'b0, 4'd5);
        add_random(N_RAND);
        run_stream("unsigned int_bits 5");
        finish_test("unsigned cast", e0);
    endtask

    task automatic test_signed();
        int e0;
        test_name = "signed cast";
        e0 = err_cnt;
        set_ctrl(1'b1, 1'b1, 4'd2);
        add_lanes(8'h80, 8'hff);                        // -128 and -1.
        add_lanes(8'h00, 8'h7f);
        add_lanes(8'h7f, 8'h80);
        add_random(N_RAND);
        run_stream("signed");
        finish_test("signed cast", e0);
    endtask

    task automatic test_strobes();
        int          e0;
        logic [3:0]  pattern [8] = '{4'b0001, 4'b0100, 4'b0110, 4'b1001,
                                     4'b0000, 4'b1111, 4'b0010, 4'b1000};
        test_name = "strobe expansion";
        e0 = err_cnt;
        set_ctrl(1'b1, 1'b0, 4'd0);
        for (int k = 0; k < 8; k++) begin
            stim_data.push_back(rand_bits(32));
            stim_strb.push_back(pattern[k]);
        end
        run_stream("strobes");
        finish_test("strobe expansion", e0);
    endtask

    task automatic test_backpressure();
        int          e0;
        logic [31:0] bd [2];
        logic [3:0]  bs [2];
        logic [31:0] d;
        logic [3:0]  s;
        logic [35:0] exp;
        test_name = "back-pressure";
        e0 = err_cnt;
        set_ctrl(1'b1, 1'b1, 4'd1);
        for (int k = 0; k < 2; k++) begin
            bd[k] = rand_bits(32);
            bs[k] = rand_bits(4);
            push(bd[k], bs[k]);                         // out_ready held low.
        end
        @(posedge clk);
        check_bit("backpressure in_ready", 1'b0, in_ready);
        check_bit("backpressure out_valid", 1'b1, out_valid);
        for (int k = 0; k < 2; k++) begin
            pop(d, s);
            exp = cast_model(cfg_en, cfg_sgn, cfg_ib, bd[k], bs[k]);
            check_word("backpressure data", exp[31:0], d);
            check_strb("backpressure strb", exp[35:32], s);
        end
        @(posedge clk);
        check_bit("drained in_ready", 1'b1, in_ready);
        check_bit("drained out_valid", 1'b0, out_valid);
        finish_test("back-pressure", e0);
    endtask

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        in_valid     = 1'b0;
        in_data      = '0;
        in_strb      = '0;
        out_ready    = 1'b0;
        cfg_en       = 1'b0;
        cfg_sgn      = 1'b0;
        cfg_ib       = '0;
        test_name    = "reset";
        err_cnt      = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_registers();
        test_bypass();
        test_unsigned();
        test_signed();
        test_strobes();
        test_backpressure();
        $display("summary: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
design/softex_pkg.sv
design/softex_lzc_tree.sv
design/softex_cast_in.sv
design/softex_cast_regs.sv
design/softex_stream_buffer.sv
design/softex_cast_top.sv
tests/tb_softex_cast.sv
